/* design/core_mem_pkg.sv */
package core_mem_pkg;

    // ========================================
    // Bus and memory geometry
    // ========================================
    parameter int GBUS_DATA   = 64;   // Word width on every bus and bank
    parameter int GBUS_ADDR   = 12;   // Top bit selects the bank
    parameter int WMEM_DEPTH  = 512;
    parameter int CACHE_DEPTH = 256;
    parameter int LBUF_DEPTH  = 64;
    parameter int ALERT_DEPTH = 3;    // Slack below full for almost-full

    typedef logic [GBUS_DATA-1:0] gbus_data_t;
    typedef logic [GBUS_ADDR-1:0] gbus_addr_t;

    // ========================================
    // Bank select and read source tags
    // ========================================

    // Value of the address MSB
    typedef enum logic {
        SEL_WMEM  = 1'b0,
        SEL_CACHE = 1'b1
    } mem_sel_e;

    // Who owns the read issued to a bank this cycle
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_GBUS = 2'd1,
        SRC_CMEM = 2'd2
    } rd_src_e;

endpackage

/* design/mem_port_if.sv */
`timescale 1ns/1ps

// Access port of one single-port bank
interface mem_port_if #(
    parameter int DEPTH = 256
);
    localparam int AW = $clog2(DEPTH);

    logic [AW-1:0]             addr;
    logic                      wen;
    core_mem_pkg::gbus_data_t  wdata;
    logic                      ren;
    core_mem_pkg::gbus_data_t  rdata;   // Valid the cycle after ren

    // Request side, driven by the decoder
    modport ctrl (
        output addr, wen, wdata, ren
    );

    // The memory itself
    modport bank (
        input  addr, wen, wdata, ren,
        output rdata
    );

    // Read-return side only looks at data
    modport ret (
        input  rdata
    );

endinterface

/* design/core_mem_decode.sv */
`timescale 1ns/1ps

module core_mem_decode (
    input  core_mem_pkg::gbus_addr_t  gbus_addr,
    input  logic                      gbus_wen,
    input  core_mem_pkg::gbus_data_t  gbus_wdata,
    input  logic                      gbus_ren,
    input  core_mem_pkg::gbus_addr_t  cmem_raddr,
    input  logic                      cmem_ren,
    mem_port_if.ctrl                  wmem_port,
    mem_port_if.ctrl                  cache_port,
    output core_mem_pkg::rd_src_e     wmem_src,
    output core_mem_pkg::rd_src_e     cache_src
);

    core_mem_pkg::mem_sel_e gbus_sel;
    core_mem_pkg::mem_sel_e cmem_sel;
    logic                   gbus_act;

    // GBUS read wins the tag, the environment keeps CMEM off that bank
    function automatic core_mem_pkg::rd_src_e src_tag(input logic gbus_rd,
                                                      input logic cmem_rd);
        if (gbus_rd) begin
            return core_mem_pkg::SRC_GBUS;
        end
        if (cmem_rd) begin
            return core_mem_pkg::SRC_CMEM;
        end
        return core_mem_pkg::SRC_NONE;
    endfunction

    assign gbus_sel = core_mem_pkg::mem_sel_e'(gbus_addr[core_mem_pkg::GBUS_ADDR-1]);
    assign cmem_sel = core_mem_pkg::mem_sel_e'(cmem_raddr[core_mem_pkg::GBUS_ADDR-1]);
    assign gbus_act = gbus_wen || gbus_ren;

    // ========================================
    // Weight memory
    // ========================================
    always_comb begin
        if (gbus_act && gbus_sel == core_mem_pkg::SEL_WMEM) begin
            wmem_port.addr = gbus_addr[wmem_port.AW-1:0];   // Upper bits alias
        end else begin
            wmem_port.addr = cmem_raddr[wmem_port.AW-1:0];
        end
        wmem_port.wen   = gbus_wen && gbus_sel == core_mem_pkg::SEL_WMEM;
        wmem_port.wdata = gbus_wdata;
        wmem_src = src_tag(gbus_ren && gbus_sel == core_mem_pkg::SEL_WMEM,
                           cmem_ren && cmem_sel == core_mem_pkg::SEL_WMEM);
        wmem_port.ren   = wmem_src != core_mem_pkg::SRC_NONE;
    end

    // ========================================
    // KV cache
    // ========================================
    always_comb begin
        if (gbus_act && gbus_sel == core_mem_pkg::SEL_CACHE) begin
            cache_port.addr = gbus_addr[cache_port.AW-1:0];
        end else begin
            cache_port.addr = cmem_raddr[cache_port.AW-1:0];
        end
        cache_port.wen   = gbus_wen && gbus_sel == core_mem_pkg::SEL_CACHE;
        cache_port.wdata = gbus_wdata;
        cache_src = src_tag(gbus_ren && gbus_sel == core_mem_pkg::SEL_CACHE,
                            cmem_ren && cmem_sel == core_mem_pkg::SEL_CACHE);
        cache_port.ren   = cache_src != core_mem_pkg::SRC_NONE;
    end

    // Environment rules, checked once inputs settle
    always_comb begin
        a_no_bank_collision : assert final (!(gbus_act && cmem_ren && gbus_sel == cmem_sel))
            else $error("GBUS and CMEM target the same bank in one cycle");
        a_gbus_wr_rd_excl : assert final (!(gbus_wen && gbus_ren))
            else $error("gbus_wen and gbus_ren high together");
    end

endmodule

/* design/mem_sp_bank.sv */
`timescale 1ns/1ps

module mem_sp_bank #(
    parameter int DEPTH = 256
) (
    input  logic       clk,
    mem_port_if.bank   port
);

    // Storage, contents undefined until loaded over GBUS
    core_mem_pkg::gbus_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (port.wen) begin
            mem[port.addr] <= port.wdata;
        end
    end

    // Read data holds its value between reads
    always_ff @(posedge clk) begin
        if (port.ren) begin
            port.rdata <= mem[port.addr];
        end
    end

    // The decoder never reads and writes one bank in one cycle
    a_no_rw_same_cycle : assert property (@(posedge clk) !(port.wen && port.ren))
        else $error("Bank written and read in the same cycle");

endmodule

/* design/core_mem_return.sv */
`timescale 1ns/1ps

module core_mem_return (
    input  logic                      clk,
    input  logic                      rstn,
    input  core_mem_pkg::rd_src_e     wmem_src,
    input  core_mem_pkg::rd_src_e     cache_src,
    mem_port_if.ret                   wmem_ret,
    mem_port_if.ret                   cache_ret,
    output core_mem_pkg::gbus_data_t  gbus_rdata,
    output logic                      gbus_rvalid,
    output core_mem_pkg::gbus_data_t  lbuf_wdata,
    output logic                      lbuf_wen
);

    core_mem_pkg::rd_src_e wmem_src_q;   // Lines up with bank rdata
    core_mem_pkg::rd_src_e cache_src_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wmem_src_q  <= core_mem_pkg::SRC_NONE;
            cache_src_q <= core_mem_pkg::SRC_NONE;
        end else begin
            wmem_src_q  <= wmem_src;
            cache_src_q <= cache_src;
        end
    end

    // ========================================
    // Return routing
    // ========================================
    always_comb begin
        gbus_rvalid = 1'b0;
        gbus_rdata  = '0;
        lbuf_wen    = 1'b0;
        lbuf_wdata  = '0;

        if (wmem_src_q == core_mem_pkg::SRC_GBUS) begin
            gbus_rvalid = 1'b1;
            gbus_rdata  = wmem_ret.rdata;
        end else if (cache_src_q == core_mem_pkg::SRC_GBUS) begin
            gbus_rvalid = 1'b1;
            gbus_rdata  = cache_ret.rdata;
        end

        // Aligner ratio is one, so the word goes straight to LBUF
        if (wmem_src_q == core_mem_pkg::SRC_CMEM) begin
            lbuf_wen   = 1'b1;
            lbuf_wdata = wmem_ret.rdata;
        end else if (cache_src_q == core_mem_pkg::SRC_CMEM) begin
            lbuf_wen   = 1'b1;
            lbuf_wdata = cache_ret.rdata;
        end
    end

    a_tags_distinct : assert property (@(posedge clk) disable iff (!rstn)
        !(wmem_src_q != core_mem_pkg::SRC_NONE && wmem_src_q == cache_src_q))
        else $error("Both banks returning to the same source");

endmodule

/* design/lbuf_fifo.sv */
`timescale 1ns/1ps

module lbuf_fifo #(
    parameter int DEPTH       = 64,   // Power of two
    parameter int ALERT_DEPTH = 3
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  core_mem_pkg::gbus_data_t  wdata,
    input  logic                      wen,
    input  logic                      ren,
    output core_mem_pkg::gbus_data_t  rdata,
    output logic                      rvalid,
    output logic                      empty,
    output logic                      full,
    output logic                      almost_full
);

    localparam int AW = $clog2(DEPTH);

    core_mem_pkg::gbus_data_t mem [DEPTH];

    logic [AW:0] wptr;    // MSB is the wrap bit
    logic [AW:0] rptr;
    logic [AW:0] count;
    logic        push;
    logic        pop;

    // ========================================
    // Occupancy and flags
    // ========================================
    assign count       = wptr - rptr;   // Wraps correctly with the extra bit
    assign empty       = count == '0;
    assign full        = count == (AW+1)'(DEPTH);
    assign almost_full = count >= (AW+1)'(DEPTH - ALERT_DEPTH);

    assign push = wen && !full;   // Overflow words are dropped
    assign pop  = ren && !empty;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    // ========================================
    // Storage and read port
    // ========================================
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr[AW-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rdata <= mem[rptr[AW-1:0]];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= pop;
        end
    end

    a_count_bound : assert property (@(posedge clk) disable iff (!rstn)
        count <= (AW+1)'(DEPTH))
        else $error("LBUF count above depth");

    // Underflow pop must not produce a word
    a_no_rvalid_underflow : assert property (@(posedge clk) disable iff (!rstn)
        ren && empty |=> !rvalid)
        else $error("rvalid after pop on empty LBUF");

endmodule

/* design/core_mem_top.sv */
`timescale 1ns/1ps

module core_mem_top (
    input  logic                      clk,
    input  logic                      rstn,
    // Global bus, loading and debug read-back
    input  core_mem_pkg::gbus_addr_t  gbus_addr,
    input  logic                      gbus_wen,
    input  core_mem_pkg::gbus_data_t  gbus_wdata,
    input  logic                      gbus_ren,
    output core_mem_pkg::gbus_data_t  gbus_rdata,
    output logic                      gbus_rvalid,
    // Core read channel into LBUF
    input  core_mem_pkg::gbus_addr_t  cmem_raddr,
    input  logic                      cmem_ren,
    // LBUF towards the MAC array
    input  logic                      lbuf_ren,
    output core_mem_pkg::gbus_data_t  lbuf_rdata,
    output logic                      lbuf_rvalid,
    output logic                      lbuf_empty,
    output logic                      lbuf_full,
    output logic                      lbuf_almost_full
);

    core_mem_pkg::rd_src_e    wmem_src;
    core_mem_pkg::rd_src_e    cache_src;
    core_mem_pkg::gbus_data_t lbuf_wdata;
    logic                     lbuf_wen;

    // Address MSB == SEL_WMEM goes here
    mem_port_if #(.DEPTH(core_mem_pkg::WMEM_DEPTH))  wmem_if ();
    // Address MSB == SEL_CACHE goes here
    mem_port_if #(.DEPTH(core_mem_pkg::CACHE_DEPTH)) cache_if ();

    // ========================================
    // Request decode and banks
    // ========================================
    core_mem_decode u_decode (
        .gbus_addr  (gbus_addr),
        .gbus_wen   (gbus_wen),
        .gbus_wdata (gbus_wdata),
        .gbus_ren   (gbus_ren),
        .cmem_raddr (cmem_raddr),
        .cmem_ren   (cmem_ren),
        .wmem_port  (wmem_if.ctrl),
        .cache_port (cache_if.ctrl),
        .wmem_src   (wmem_src),
        .cache_src  (cache_src)
    );

    mem_sp_bank #(.DEPTH(core_mem_pkg::WMEM_DEPTH)) u_wmem (
        .clk  (clk),
        .port (wmem_if.bank)
    );

    mem_sp_bank #(.DEPTH(core_mem_pkg::CACHE_DEPTH)) u_cache (
        .clk  (clk),
        .port (cache_if.bank)
    );

    // ========================================
    // Read return and local buffer
    // ========================================
    core_mem_return u_return (
        .clk         (clk),
        .rstn        (rstn),
        .wmem_src    (wmem_src),
        .cache_src   (cache_src),
        .wmem_ret    (wmem_if.ret),
        .cache_ret   (cache_if.ret),
        .gbus_rdata  (gbus_rdata),
        .gbus_rvalid (gbus_rvalid),
        .lbuf_wdata  (lbuf_wdata),
        .lbuf_wen    (lbuf_wen)
    );

    lbuf_fifo #(
        .DEPTH       (core_mem_pkg::LBUF_DEPTH),
        .ALERT_DEPTH (core_mem_pkg::ALERT_DEPTH)
    ) u_lbuf (
        .clk         (clk),
        .rstn        (rstn),
        .wdata       (lbuf_wdata),
        .wen         (lbuf_wen),
        .ren         (lbuf_ren),
        .rdata       (lbuf_rdata),
        .rvalid      (lbuf_rvalid),
        .empty       (lbuf_empty),
        .full        (lbuf_full),
        .almost_full (lbuf_almost_full)
    );

endmodule

/* tests/tb_core_mem.sv */
`timescale 1ns/1ps

module tb_core_mem;

    localparam int DEPTH = core_mem_pkg::LBUF_DEPTH;
    localparam int MSB   = core_mem_pkg::GBUS_ADDR - 1;

    logic                     clk;
    logic                     rstn;
    core_mem_pkg::gbus_addr_t gbus_addr;
    logic                     gbus_wen;
    core_mem_pkg::gbus_data_t gbus_wdata;
    logic                     gbus_ren;
    core_mem_pkg::gbus_data_t gbus_rdata;
    logic                     gbus_rvalid;
    core_mem_pkg::gbus_addr_t cmem_raddr;
    logic                     cmem_ren;
    logic                     lbuf_ren;
    core_mem_pkg::gbus_data_t lbuf_rdata;
    logic                     lbuf_rvalid;
    logic                     lbuf_empty;
    logic                     lbuf_full;
    logic                     lbuf_almost_full;

    // ========================================
    // Reference model state
    // ========================================
    core_mem_pkg::gbus_data_t wmem_model [int];
    core_mem_pkg::gbus_data_t cache_model [int];
    core_mem_pkg::gbus_data_t lbuf_model [$];
    core_mem_pkg::gbus_addr_t addrs [$];     // Written addresses, WMEM and CACHE alternating
    core_mem_pkg::gbus_data_t gbus_rd_exp;
    core_mem_pkg::gbus_data_t lbuf_rd_exp;
    core_mem_pkg::gbus_data_t cmem_word;     // Word on its way to LBUF
    logic                     gbus_rv_exp;
    logic                     lbuf_rv_exp;
    logic                     cmem_pend;
    logic                     do_pop;
    logic                     do_push;
    int                       errors;
    int                       checks;

    core_mem_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Index inside the bank; bits above its width alias
    function automatic int bank_index(input core_mem_pkg::gbus_addr_t a);
        if (a[MSB]) begin
            return int'(a[MSB-1:0]) % core_mem_pkg::CACHE_DEPTH;
        end
        return int'(a[MSB-1:0]) % core_mem_pkg::WMEM_DEPTH;
    endfunction

    function automatic core_mem_pkg::gbus_data_t model_read(input core_mem_pkg::gbus_addr_t a);
        if (a[MSB]) begin
            return cache_model[bank_index(a)];
        end
        return wmem_model[bank_index(a)];
    endfunction

    function automatic core_mem_pkg::gbus_data_t random_word();
        return {$urandom, $urandom};
    endfunction

    // Model advances on the same edge as the DUT, reads before writes
    always @(posedge clk) begin
        if (!rstn) begin
            lbuf_model.delete();
            gbus_rv_exp = 1'b0;
            lbuf_rv_exp = 1'b0;
            cmem_pend   = 1'b0;
        end else begin
            do_pop  = lbuf_ren && lbuf_model.size() > 0;
            do_push = cmem_pend && lbuf_model.size() < DEPTH;   // Dropped when full
            lbuf_rv_exp = do_pop;
            if (do_pop) begin
                lbuf_rd_exp = lbuf_model.pop_front();
            end
            if (do_push) begin
                lbuf_model.push_back(cmem_word);
            end
            cmem_pend = cmem_ren;
            if (cmem_ren) begin
                cmem_word = model_read(cmem_raddr);
            end
            gbus_rv_exp = gbus_ren;
            if (gbus_ren) begin
                gbus_rd_exp = model_read(gbus_addr);
            end
            if (gbus_wen && gbus_addr[MSB]) begin
                cache_model[bank_index(gbus_addr)] = gbus_wdata;
            end else if (gbus_wen) begin
                wmem_model[bank_index(gbus_addr)] = gbus_wdata;
            end
        end
    end

    // ========================================
    // Checking
    // ========================================
    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        errors++;
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            checks++;
            a_gbus_rvalid : assert (gbus_rvalid === gbus_rv_exp)
                else report_value("gbus_rvalid", gbus_rv_exp, gbus_rvalid);
            if (gbus_rv_exp) begin
                a_gbus_rdata : assert (gbus_rdata === gbus_rd_exp)
                    else report_value("gbus_rdata", gbus_rd_exp, gbus_rdata);
            end
            a_lbuf_rvalid : assert (lbuf_rvalid === lbuf_rv_exp)
                else report_value("lbuf_rvalid", lbuf_rv_exp, lbuf_rvalid);
            if (lbuf_rv_exp) begin
                a_lbuf_rdata : assert (lbuf_rdata === lbuf_rd_exp)
                    else report_value("lbuf_rdata", lbuf_rd_exp, lbuf_rdata);
            end
            a_empty : assert (lbuf_empty === (lbuf_model.size() == 0))
                else report_value("lbuf_empty", lbuf_model.size() == 0, lbuf_empty);
            a_full : assert (lbuf_full === (lbuf_model.size() == DEPTH))
                else report_value("lbuf_full", lbuf_model.size() == DEPTH, lbuf_full);
            a_almost : assert (lbuf_almost_full ===
                               (lbuf_model.size() >= DEPTH - core_mem_pkg::ALERT_DEPTH))
                else report_value("lbuf_almost_full",
                                  lbuf_model.size() >= DEPTH - core_mem_pkg::ALERT_DEPTH,
                                  lbuf_almost_full);
        end
    end

    a_full_has_almost : assert property (@(posedge clk) disable iff (!rstn)
        lbuf_full |-> lbuf_almost_full)
        else begin
            errors++;
            $display("LBUF full without almost-full at %0t", $time);
        end

    a_not_empty_and_full : assert property (@(posedge clk) disable iff (!rstn)
        !(lbuf_empty && lbuf_full))
        else begin
            errors++;
            $display("LBUF flags empty and full at once at %0t", $time);
        end

    // ========================================
    // Stimulus
    // ========================================
    task automatic drive_cycle(input logic wen, input logic ren,
                               input core_mem_pkg::gbus_addr_t ga,
                               input core_mem_pkg::gbus_data_t wd,
                               input logic cren, input core_mem_pkg::gbus_addr_t ca,
                               input logic lren);
        @(posedge clk);
        #1;
        gbus_wen   = wen;
        gbus_ren   = ren;
        gbus_addr  = ga;
        gbus_wdata = wd;
        cmem_ren   = cren;
        cmem_raddr = ca;
        lbuf_ren   = lren;
    endtask

    task automatic gbus_write(input core_mem_pkg::gbus_addr_t a);
        drive_cycle(1'b1, 1'b0, a, random_word(), 1'b0, '0, 1'b0);
    endtask

    task automatic gbus_read(input core_mem_pkg::gbus_addr_t a);
        drive_cycle(1'b0, 1'b1, a, '0, 1'b0, '0, 1'b0);
    endtask

    task automatic cmem_read(input core_mem_pkg::gbus_addr_t a);
        drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, a, 1'b0);
    endtask

    task automatic end_run();
        $display("%0d cycles checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    // Pop until LBUF is empty and nothing is in flight
    task automatic drain_lbuf(input int limit);
        int n;
        n = 0;
        do begin
            drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b1);
            n++;
        end while ((!lbuf_empty || cmem_pend) && n < limit);
        drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        if (!lbuf_empty || cmem_pend) begin
            errors++;
            $display("Timeout: LBUF not drained after %0d pops", limit);
            end_run();
        end
    endtask

    initial begin
        void'($urandom(14349));
        errors     = 0;
        checks     = 0;
        rstn       = 1'b0;
        gbus_addr  = '0;
        gbus_wen   = 1'b0;
        gbus_wdata = '0;
        gbus_ren   = 1'b0;
        cmem_raddr = '0;
        cmem_ren   = 1'b0;
        lbuf_ren   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        // GBUS round trip over both banks
        for (int i = 0; i < 24; i++) begin
            addrs.push_back({i[0], 11'($urandom)});
            gbus_write(addrs[i]);
        end
        foreach (addrs[i]) begin
            gbus_read(addrs[i]);
        end

        // Same low address in both banks, plus aliases
        gbus_write(12'h005);
        gbus_write(12'h805);
        gbus_read(12'h005);
        gbus_read(12'h805);
        gbus_read(12'h905);   // CACHE, bit 8 ignored
        gbus_read(12'h605);   // WMEM, bits 9 and 10 ignored

        // CMEM burst into LBUF
        for (int i = 0; i < 10; i++) begin
            cmem_read(addrs[i]);
        end
        drain_lbuf(40);

        // GBUS and CMEM on opposite banks, back to back
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b0, 1'b1, addrs[2*i], '0, 1'b1, addrs[2*i+1], 1'b0);
        end
        drain_lbuf(40);

        // Overfill LBUF, the last two words are dropped
        for (int i = 0; i < DEPTH + 2; i++) begin
            cmem_read(addrs[i % addrs.size()]);
        end
        drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        drain_lbuf(DEPTH + 8);

        // Pop on empty LBUF
        drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b1);
        repeat (2) drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0, 1'b0);
        end_run();
    end

endmodule

/* project.f */
design/core_mem_pkg.sv
design/mem_port_if.sv
design/core_mem_decode.sv
design/mem_sp_bank.sv
design/core_mem_return.sv
design/lbuf_fifo.sv
design/core_mem_top.sv
tests/tb_core_mem.sv

/* Bender.yml */
package:
  name: core_mem

sources:
  - design/core_mem_pkg.sv
  - design/mem_port_if.sv
  - design/core_mem_decode.sv
  - design/mem_sp_bank.sv
  - design/core_mem_return.sv
  - design/lbuf_fifo.sv
  - design/core_mem_top.sv
  - target: test
    files:
      - tests/tb_core_mem.sv
